/* aes_pkg.sv */
package aes_pkg;

    // --------------------------------------------------------------------------
    // sizes
    // --------------------------------------------------------------------------

    // bits per byte
    localparam int AES_NB_BYTE  = 8;
    // bytes per state
    localparam int AES_N_BYTES  = 16;
    // columns per state
    localparam int AES_N_COLS   = 4;
    // rows per column, one byte each
    localparam int AES_N_ROWS   = AES_N_BYTES / AES_N_COLS;
    // bits per column word
    localparam int AES_NB_WORD  = AES_N_ROWS * AES_NB_BYTE;
    // bits per state or key
    localparam int AES_NB_BLOCK = AES_N_BYTES * AES_NB_BYTE;
    // index of the last round
    localparam int AES_N_ROUNDS = 10;
    // one register per round stage, rounds 0 to 10
    localparam int AES_LATENCY  = AES_N_ROUNDS + 1;
    // user tag width
    localparam int AES_NB_TAG   = 16;

    // reduction term of x^8 + x^4 + x^3 + x + 1
    localparam logic [AES_NB_BYTE-1:0] AES_GF_POLY = 8'h1b;

    // --------------------------------------------------------------------------
    // types
    // --------------------------------------------------------------------------

    typedef logic [AES_NB_TAG-1:0] aes_tag_t;

    // byte 0 is the msb, column-major as in fips-197
    // byte view for sbox and row shifts, column view for mixing and key words
    typedef union packed {
        logic [0:AES_N_BYTES-1][AES_NB_BYTE-1:0] bytes;
        logic [0:AES_N_COLS-1][AES_NB_WORD-1:0]  cols;
    } aes_state_t;

    // --------------------------------------------------------------------------
    // forward sbox, one row of 16 entries per line
    // --------------------------------------------------------------------------

    localparam logic [0:255][AES_NB_BYTE-1:0] AES_SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // --------------------------------------------------------------------------
    // byte functions
    // --------------------------------------------------------------------------

    // table lookup, element 0 sits at the msb end
    function automatic logic [AES_NB_BYTE-1:0] aes_sbox(input logic [AES_NB_BYTE-1:0] b);
        return AES_SBOX_TABLE[b];
    endfunction

    // multiply by x in gf(2^8)
    function automatic logic [AES_NB_BYTE-1:0] aes_xtime(input logic [AES_NB_BYTE-1:0] b);
        logic [AES_NB_BYTE-1:0] shifted;
        shifted = {b[AES_NB_BYTE-2:0], 1'b0};
        // reduce when the top bit falls off
        return b[AES_NB_BYTE-1] ? (shifted ^ AES_GF_POLY) : shifted;
    endfunction

    // rcon[round] = x^(round-1), round from 1 to 10
    function automatic logic [AES_NB_BYTE-1:0] aes_rcon(input int round);
        logic [AES_NB_BYTE-1:0] rc;
        rc = 8'h01;
        // fixed bound, the round index only gates the doubling
        for (int i = 1; i < AES_N_ROUNDS; i++)
        begin
            if (i < round)
            begin
                rc = aes_xtime(rc);
            end
        end
        return rc;
    endfunction

endpackage

/* aes_sub_shift.sv */
`timescale 1ns/100ps

// subbytes then shiftrows, both at byte level
module aes_sub_shift
    import aes_pkg::*;
(
    input  aes_state_t i_state,
    output aes_state_t o_state
);

    // state after the sbox, before the row rotation
    aes_state_t sub_state;

    // --------------------------------------------------------------------------
    // subbytes
    // --------------------------------------------------------------------------

    // one sbox lookup per byte
    always_comb
    begin
        for (int b = 0; b < AES_N_BYTES; b++)
        begin
            sub_state.bytes[b] = aes_sbox(i_state.bytes[b]);
        end
    end

    // --------------------------------------------------------------------------
    // shiftrows
    // --------------------------------------------------------------------------

    // row r rotates left by r columns
    // byte at (row r, col c) is bytes[4*c + r]
    always_comb
    begin
        for (int c = 0; c < AES_N_COLS; c++)
        begin
            for (int r = 0; r < AES_N_ROWS; r++)
            begin
                // pick from column c+r of the same row
                o_state.bytes[AES_N_ROWS*c + r] =
                    sub_state.bytes[AES_N_ROWS*((c + r) % AES_N_COLS) + r];
            end
        end
    end

endmodule

/* aes_mix_columns.sv */
`timescale 1ns/100ps

// mixcolumns, one fixed matrix product per 32-bit column
module aes_mix_columns
    import aes_pkg::*;
(
    input  aes_state_t i_state,
    output aes_state_t o_state
);

    genvar c;

    // --------------------------------------------------------------------------
    // per column product
    // --------------------------------------------------------------------------

    // matrix rows are 2 3 1 1, rotated right by one each row
    // 3*a is built as 2*a ^ a
    generate
        for (c = 0; c < AES_N_COLS; c++)
        begin : gen_col
            // column bytes, a0 is the top row
            logic [AES_NB_BYTE-1:0] a0;
            logic [AES_NB_BYTE-1:0] a1;
            logic [AES_NB_BYTE-1:0] a2;
            logic [AES_NB_BYTE-1:0] a3;
            // doubled bytes
            logic [AES_NB_BYTE-1:0] d0;
            logic [AES_NB_BYTE-1:0] d1;
            logic [AES_NB_BYTE-1:0] d2;
            logic [AES_NB_BYTE-1:0] d3;

            assign {a0, a1, a2, a3} = i_state.cols[c];

            assign d0 = aes_xtime(a0);
            assign d1 = aes_xtime(a1);
            assign d2 = aes_xtime(a2);
            assign d3 = aes_xtime(a3);

            // out rows 0 to 3, msb first
            assign o_state.cols[c] = {
                d0 ^ d1 ^ a1 ^ a2 ^ a3,
                a0 ^ d1 ^ d2 ^ a2 ^ a3,
                a0 ^ a1 ^ d2 ^ d3 ^ a3,
                d0 ^ a0 ^ a1 ^ a2 ^ d3
            };
        end
    endgenerate

endmodule

/* aes_key_expand_stage.sv */
`timescale 1ns/100ps

// one registered step of the aes-128 key schedule
module aes_key_expand_stage
    import aes_pkg::*;
#(
    // round whose key comes out (1 to 10)
    parameter int ROUND_INDEX = 1
)
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_valid,
    input  aes_state_t i_key,
    output aes_state_t o_key
);

    // fixed round constant of this instance
    localparam logic [AES_NB_BYTE-1:0] RCON = aes_rcon(ROUND_INDEX);

    // rotword, subword and rcon applied to the last word
    logic [AES_NB_WORD-1:0] temp_word;
    // new key words, each chained on the one before
    logic [AES_NB_WORD-1:0] new_word0;
    logic [AES_NB_WORD-1:0] new_word1;
    logic [AES_NB_WORD-1:0] new_word2;
    logic [AES_NB_WORD-1:0] new_word3;
    // next key before the register
    aes_state_t             key_next;

    // --------------------------------------------------------------------------
    // g function on column 3
    // --------------------------------------------------------------------------

    // last column holds bytes 12 to 15
    // rotated left by one byte on the way into the sbox
    assign temp_word = {
        aes_sbox(i_key.bytes[13]) ^ RCON,
        aes_sbox(i_key.bytes[14]),
        aes_sbox(i_key.bytes[15]),
        aes_sbox(i_key.bytes[12])
    };

    // --------------------------------------------------------------------------
    // word chain
    // --------------------------------------------------------------------------

    // each new word is the previous new word ^ the old word
    assign new_word0 = i_key.cols[0] ^ temp_word;
    assign new_word1 = i_key.cols[1] ^ new_word0;
    assign new_word2 = i_key.cols[2] ^ new_word1;
    assign new_word3 = i_key.cols[3] ^ new_word2;

    // word 0 lands in the top column
    assign key_next.cols = {new_word0, new_word1, new_word2, new_word3};

    // key moves with its block and holds otherwise
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_key <= {AES_NB_BLOCK{1'b0}};
        end
        else if (i_valid)
        begin
            o_key <= key_next;
        end
    end

endmodule

/* aes_round_stage.sv */
`timescale 1ns/100ps

// one cipher round with its output register
// round 0 is addroundkey only, round 10 drops mixcolumns
module aes_round_stage
    import aes_pkg::*;
#(
    // 0 to 10
    parameter int ROUND_INDEX = 1
)
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_valid,
    input  aes_state_t i_state,
    input  aes_state_t i_round_key,
    input  aes_tag_t   i_tag,
    output logic       o_valid,
    output aes_state_t o_state,
    output aes_tag_t   o_tag
);

    // round result before the register
    aes_state_t add_key_state;

    // --------------------------------------------------------------------------
    // round datapath
    // --------------------------------------------------------------------------

    generate
        if (ROUND_INDEX == 0)
        begin : gen_first_round
            // initial whitening with the cipher key
            assign add_key_state = i_state ^ i_round_key;
        end
        else
        begin : gen_cipher_round
            aes_state_t shifted_state;
            aes_state_t mixed_state;

            // sbox and row rotation
            aes_sub_shift u_sub_shift
            (
                .i_state (i_state),
                .o_state (shifted_state)
            );

            if (ROUND_INDEX == AES_N_ROUNDS)
            begin : gen_last_round
                // no mixcolumns in the final round
                assign mixed_state = shifted_state;
            end
            else
            begin : gen_mid_round
                aes_mix_columns u_mix_columns
                (
                    .i_state (shifted_state),
                    .o_state (mixed_state)
                );
            end

            assign add_key_state = mixed_state ^ i_round_key;
        end
    endgenerate

    // --------------------------------------------------------------------------
    // output register
    // --------------------------------------------------------------------------

    // state and tag share one load enable, valid runs every cycle
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
            o_state <= {AES_NB_BLOCK{1'b0}};
            o_tag   <= {AES_NB_TAG{1'b0}};
        end
        else
        begin
            o_valid <= i_valid;
            if (i_valid)
            begin
                o_state <= add_key_state;
                o_tag   <= i_tag;
            end
        end
    end

endmodule

/* aes128_encrypt_pipe.sv */
`timescale 1ns/100ps

// aes-128 encryption, eleven registered rounds, one block per clock
// each block brings its own key, expanded alongside the rounds
module aes128_encrypt_pipe
    import aes_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_valid,
    input  aes_state_t i_plaintext,
    input  aes_state_t i_key,
    input  aes_tag_t   i_tag,
    output logic       o_valid,
    output aes_state_t o_ciphertext,
    output aes_tag_t   o_tag
);

    genvar k;

    // --------------------------------------------------------------------------
    // pipeline links, index k feeds round stage k
    // --------------------------------------------------------------------------

    // entry 11 is the pipe output
    logic       valid_pipe [0:AES_N_ROUNDS+1];
    aes_state_t state_pipe [0:AES_N_ROUNDS+1];
    aes_tag_t   tag_pipe   [0:AES_N_ROUNDS+1];
    // key k is round key k, key 0 is the cipher key
    aes_state_t key_pipe   [0:AES_N_ROUNDS];

    assign valid_pipe[0] = i_valid;
    assign state_pipe[0] = i_plaintext;
    assign tag_pipe[0]   = i_tag;
    assign key_pipe[0]   = i_key;

    // --------------------------------------------------------------------------
    // stages
    // --------------------------------------------------------------------------

    generate
        for (k = 0; k <= AES_N_ROUNDS; k++)
        begin : gen_stage
            aes_round_stage #(
                .ROUND_INDEX (k)
            ) u_round_stage (
                .i_clock     (i_clock),
                .i_reset     (i_reset),
                .i_valid     (valid_pipe[k]),
                .i_state     (state_pipe[k]),
                .i_round_key (key_pipe[k]),
                .i_tag       (tag_pipe[k]),
                .o_valid     (valid_pipe[k+1]),
                .o_state     (state_pipe[k+1]),
                .o_tag       (tag_pipe[k+1])
            );

            // key k+1 lands with state k+1, none after the last round
            if (k < AES_N_ROUNDS)
            begin : gen_key
                aes_key_expand_stage #(
                    .ROUND_INDEX (k + 1)
                ) u_key_stage (
                    .i_clock (i_clock),
                    .i_reset (i_reset),
                    .i_valid (valid_pipe[k]),
                    .i_key   (key_pipe[k]),
                    .o_key   (key_pipe[k+1])
                );
            end
        end
    endgenerate

    // last round register drives the outputs
    assign o_valid      = valid_pipe[AES_N_ROUNDS+1];
    assign o_ciphertext = state_pipe[AES_N_ROUNDS+1];
    assign o_tag        = tag_pipe[AES_N_ROUNDS+1];

endmodule

/* tb_aes_model.svh */
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// --------------------------------------------------------------------------
// aes-128 reference encryption, fips-197 byte order
// --------------------------------------------------------------------------

// byte i of the state sits at row i%4, column i/4
function automatic aes_state_t model_encrypt(input aes_state_t plain, input aes_state_t cipher_key);
    logic [7:0] s [0:15];
    logic [7:0] t [0:15];
    logic [7:0] rk [0:15];
    logic [7:0] w [0:3];
    aes_state_t result;

    // round 0, whitening with the cipher key
    for (int i = 0; i < 16; i++)
    begin
        rk[i] = cipher_key.bytes[i];
        s[i]  = plain.bytes[i] ^ rk[i];
    end

    for (int rnd = 1; rnd <= AES_N_ROUNDS; rnd++)
    begin
        // key schedule, rotword + subword + rcon on the last word
        w[0] = aes_sbox(rk[13]) ^ aes_rcon(rnd);
        w[1] = aes_sbox(rk[14]);
        w[2] = aes_sbox(rk[15]);
        w[3] = aes_sbox(rk[12]);
        for (int i = 0; i < 4; i++)
        begin
            rk[i] = rk[i] ^ w[i];
        end
        // later words chain on the freshly updated word before them
        for (int i = 4; i < 16; i++)
        begin
            rk[i] = rk[i] ^ rk[i-4];
        end

        // subbytes and shiftrows, row r takes column c+r
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                t[4*c + r] = aes_sbox(s[4*((c + r) % 4) + r]);
            end
        end

        // mixcolumns: out_r = 2*a_r ^ 3*a_r+1 ^ a_r+2 ^ a_r+3
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                if (rnd < AES_N_ROUNDS)
                begin
                    s[4*c + r] = aes_xtime(t[4*c + r])
                               ^ aes_xtime(t[4*c + (r + 1) % 4]) ^ t[4*c + (r + 1) % 4]
                               ^ t[4*c + (r + 2) % 4]
                               ^ t[4*c + (r + 3) % 4];
                end
                else
                begin
                    s[4*c + r] = t[4*c + r];
                end
            end
        end

        // addroundkey
        for (int i = 0; i < 16; i++)
        begin
            s[i] = s[i] ^ rk[i];
        end
    end

    for (int i = 0; i < 16; i++)
    begin
        result.bytes[i] = s[i];
    end
    return result;
endfunction

`endif

/* tb_aes128_encrypt_pipe.sv */
`timescale 1ns/100ps

module tb_aes128_encrypt_pipe
    import aes_pkg::*;
();

    // --------------------------------------------------------------------------
    // test sizes and run limit
    // --------------------------------------------------------------------------

    localparam int RESET_CYCLES   = 3;
    localparam int STREAM_BLOCKS  = 40;
    localparam int GAPPED_BLOCKS  = 30;
    localparam int FLIGHT_BLOCKS  = 8;
    localparam int QUIET_CYCLES   = 15;
    localparam int N_TESTS        = 5;
    // gapped stream sends on about 3 of 4 cycles, twice its count is ample
    localparam int TEST_CYCLES    = 2 + 1 + STREAM_BLOCKS + 2 * GAPPED_BLOCKS
                                  + FLIGHT_BLOCKS + RESET_CYCLES + QUIET_CYCLES + 1;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES
                                  + N_TESTS * 2 * AES_LATENCY + 350;

    logic       i_clock;
    logic       i_reset;
    logic       i_valid;
    aes_state_t i_plaintext;
    aes_state_t i_key;
    aes_tag_t   i_tag;
    logic       o_valid;
    aes_state_t o_ciphertext;
    aes_tag_t   o_tag;

    // scoreboard, one entry per block in flight
    aes_state_t exp_states [$];
    aes_tag_t   exp_tags [$];
    // i_valid as sampled on the last 11 edges, bit 0 newest
    logic [AES_LATENCY-1:0] valid_hist;

    int seed;
    int error_count;
    int errors_at_start;
    int tests_passed;
    int tests_failed;
    int cycle_count;

    `include "tb_aes_model.svh"

    aes128_encrypt_pipe aes128_encrypt_pipe_inst
    (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_plaintext  (i_plaintext),
        .i_key        (i_key),
        .i_tag        (i_tag),
        .o_valid      (o_valid),
        .o_ciphertext (o_ciphertext),
        .o_tag        (o_tag)
    );

    always #2 i_clock = ~i_clock;

    // --------------------------------------------------------------------------
    // compare tasks
    // --------------------------------------------------------------------------

    task automatic compare_state(input string name, input aes_state_t expected,
                                 input aes_state_t actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_tag(input string name, input aes_tag_t expected, input aes_tag_t actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        error_count++;
    endtask

    // --------------------------------------------------------------------------
    // output monitor
    // --------------------------------------------------------------------------

    // a reset edge empties every stage
    always @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid_hist <= '0;
        end
        else
        begin
            valid_hist <= {valid_hist[AES_LATENCY-2:0], i_valid};
        end
    end

    // mid-cycle sampling, o_valid must repeat i_valid 11 edges late
    always @(negedge i_clock)
    begin
        compare_valid("o_valid", valid_hist[AES_LATENCY-1], o_valid);
        if (o_valid === 1'b1)
        begin
            if (exp_states.size() == 0)
            begin
                report_error("unexpected output, o_valid high with no block in flight");
            end
            else
            begin
                compare_state("o_ciphertext", exp_states.pop_front(), o_ciphertext);
                compare_tag("o_tag", exp_tags.pop_front(), o_tag);
            end
        end
    end

    always @(posedge i_clock)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("ERROR: run stopped after %0d cycles without finishing", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------------------------------------------------------------
    // drive helpers, all on the falling edge
    // --------------------------------------------------------------------------

    function automatic aes_state_t rand_state();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic drive_block(input aes_state_t pt, input aes_state_t key, input aes_tag_t tag,
                               input aes_state_t expected);
        @(negedge i_clock);
        i_valid     = 1'b1;
        i_plaintext = pt;
        i_key       = key;
        i_tag       = tag;
        exp_states.push_back(expected);
        exp_tags.push_back(tag);
    endtask

    task automatic drive_idle();
        @(negedge i_clock);
        i_valid = 1'b0;
    endtask

    // reset already high, o_valid must read low on every reset cycle
    task automatic hold_reset();
        repeat (RESET_CYCLES)
        begin
            @(negedge i_clock);
            compare_valid("o_valid", 1'b0, o_valid);
        end
        i_reset = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge i_clock);
        i_reset = 1'b1;
        i_valid = 1'b0;
        hold_reset();
    endtask

    task automatic wait_for_outputs();
        int waited;
        waited = 0;
        while (exp_states.size() != 0 && waited < 2 * AES_LATENCY)
        begin
            drive_idle();
            waited++;
        end
        if (exp_states.size() != 0)
        begin
            report_error($sformatf("%0d missing outputs never came out", exp_states.size()));
            exp_states.delete();
            exp_tags.delete();
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        if (error_count == errors_at_start)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
    endtask

    // --------------------------------------------------------------------------
    // directed tests
    // --------------------------------------------------------------------------

    task automatic test_known_vectors();
        start_test();
        drive_block(128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f,
                    16'h0001, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        drive_block(128'h3243f6a8885a308d313198a2e0370734, 128'h2b7e151628aed2a6abf7158809cf4f3c,
                    16'h0002, 128'h3925841d02dc09fbdc118597196a0b32);
        drive_idle();
        wait_for_outputs();
        end_test("known_vectors");
    endtask

    task automatic test_fixed_latency();
        aes_state_t pt;
        aes_state_t key;
        int cycles;
        start_test();
        pt  = rand_state();
        key = rand_state();
        drive_block(pt, key, 16'hbeef, model_encrypt(pt, key));
        cycles = 0;
        do
        begin
            drive_idle();
            cycles++;
        end
        while (o_valid !== 1'b1 && cycles < 2 * AES_LATENCY);
        if (cycles != AES_LATENCY)
        begin
            report_error($sformatf("o_valid rose after %0d cycles instead of %0d",
                                   cycles, AES_LATENCY));
        end
        wait_for_outputs();
        end_test("fixed_latency");
    endtask

    task automatic test_back_to_back();
        aes_state_t pt;
        aes_state_t key;
        aes_tag_t tag;
        start_test();
        tag = 16'h0100;
        for (int i = 0; i < STREAM_BLOCKS; i++)
        begin
            pt  = rand_state();
            key = rand_state();
            drive_block(pt, key, tag, model_encrypt(pt, key));
            tag = tag + 16'd1;
        end
        drive_idle();
        wait_for_outputs();
        end_test("back_to_back");
    endtask

    // valid pattern is checked by the monitor's delayed copy
    task automatic test_gapped_stream();
        aes_state_t pt;
        aes_state_t key;
        aes_tag_t tag;
        int sent;
        start_test();
        tag  = 16'h0200;
        sent = 0;
        while (sent < GAPPED_BLOCKS)
        begin
            if (($random(seed) & 3) != 0)
            begin
                pt  = rand_state();
                key = rand_state();
                drive_block(pt, key, tag, model_encrypt(pt, key));
                tag = tag + 16'd1;
                sent++;
            end
            else
            begin
                drive_idle();
            end
        end
        drive_idle();
        wait_for_outputs();
        end_test("gapped_stream");
    endtask

    task automatic test_reset_in_flight();
        aes_state_t pt;
        aes_state_t key;
        aes_tag_t tag;
        start_test();
        tag = 16'h0300;
        for (int i = 0; i < FLIGHT_BLOCKS; i++)
        begin
            pt  = rand_state();
            key = rand_state();
            drive_block(pt, key, tag, model_encrypt(pt, key));
            tag = tag + 16'd1;
        end
        apply_reset();
        // blocks in flight are gone
        exp_states.delete();
        exp_tags.delete();
        repeat (QUIET_CYCLES)
        begin
            drive_idle();
            compare_valid("o_valid", 1'b0, o_valid);
        end
        drive_block(128'h3243f6a8885a308d313198a2e0370734, 128'h2b7e151628aed2a6abf7158809cf4f3c,
                    16'h5a5a, 128'h3925841d02dc09fbdc118597196a0b32);
        drive_idle();
        wait_for_outputs();
        end_test("reset_in_flight");
    endtask

    initial
    begin
        seed            = 94;
        error_count     = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        cycle_count     = 0;
        i_clock         = 1'b0;
        i_reset         = 1'b1;
        i_valid         = 1'b0;
        i_plaintext     = '0;
        i_key           = '0;
        i_tag           = '0;
        hold_reset();

        test_known_vectors();
        test_fixed_latency();
        test_back_to_back();
        test_gapped_stream();
        test_reset_in_flight();

        $display("%0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
aes_pkg.sv
aes_sub_shift.sv
aes_mix_columns.sv
aes_key_expand_stage.sv
aes_round_stage.sv
aes128_encrypt_pipe.sv
tb_aes128_encrypt_pipe.sv

/* run_sim.sh */
#!/bin/sh
# build the aes-128 pipeline testbench with verilator, run it,
# and decide pass or fail from what the simulation prints

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_aes128_encrypt_pipe -f verilog.f \
    || { echo "verilator build failed"; exit 1; }

sim_output=$(./obj_dir/Vtb_aes128_encrypt_pipe 2>&1)
echo "$sim_output"

echo "$sim_output" | grep -qx "Regression passed" && exit 0 || exit 1
